/* verilog.f */
+incdir+test
design/regfile_pkg.sv
design/apb_decode.sv
design/config_regs.sv
design/pulse_regs.sv
design/status_capture.sv
design/read_mux.sv
design/top_regfile.sv
test/tb_top_regfile.sv

/* test/tb_regfile_model.svh */
/*
 * Register map model: writable masks, reset values, readback reference
 * and the xorshift random source
 */
`ifndef TB_REGFILE_MODEL_SVH
`define TB_REGFILE_MODEL_SVH

// Expected readback of every word
logic [15:0] shadow [12];
logic [31:0] rng_state = 32'h4bc2;

// Map model ---------------------------
function automatic logic [15:0] word_mask(input int idx);
    case (idx)
        0:       word_mask = 16'h7fff;
        1:       word_mask = 16'h001f;
        2:       word_mask = 16'h0079;  // pulse bits 2 and 1 excluded
        3:       word_mask = 16'hffff;
        4:       word_mask = 16'h7fff;
        5:       word_mask = 16'h007f;
        8:       word_mask = 16'h01ff;
        9:       word_mask = 16'h01ff;
        10:      word_mask = 16'h0001;
        11:      word_mask = 16'h0003;
        default: word_mask = 16'h0000;
    endcase
endfunction

function automatic logic [15:0] expected_read(input int idx, input logic [15:0] data);
    expected_read = data & word_mask(idx);
endfunction

// PHY addresses all 31, both modes on, 96 path, clock enable and resets high
function automatic logic [15:0] reset_word(input int idx);
    case (idx)
        0:       reset_word = 16'h7fff;
        1:       reset_word = 16'h0014;
        2:       reset_word = 16'h0001;
        3:       reset_word = 16'h7fff;
        10:      reset_word = 16'h0001;
        11:      reset_word = 16'h0003;
        default: reset_word = 16'h0000;
    endcase
endfunction

task automatic model_reset();
    for (int i = 0; i < 12; i++) begin
        shadow[i] = reset_word(i);
    end
endtask

// Words without writable bits keep their value
task automatic model_write(input int idx, input logic [15:0] data);
    if (word_mask(idx) != 16'h0000) begin
        shadow[idx] = expected_read(idx, data);
    end
endtask

// Random source -----------------------
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic draw_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
endtask

`endif

/* test/tb_top_regfile.sv */
/*
 * Testbench for the register file: bus tasks, map checks and watchdog
 */
`default_nettype none

module tb_top_regfile;

    localparam int CLK_PERIOD = 40;
    localparam int ROUNDS     = 3;
    localparam int PKT_ROUNDS = 3;
    localparam int NUM_BAD    = 7;
    // Reset map, random rounds, pulses, status, bad addresses, final map
    localparam int NUM_TXNS   = 12 + ROUNDS * 20 + 8 + PKT_ROUNDS * 4 + NUM_BAD * 2 + 12;
    localparam int WATCHDOG_CYCLES = NUM_TXNS * 4 + 200;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [20:0] req_paddr = '0;
    logic        req_pwrite = 1'b0;
    logic        req_psel = 1'b0;
    logic        req_penable = 1'b0;
    logic [15:0] req_pwdata = '0;
    logic [8:0]  rf_mdio_pkt_data = '0;
    logic        rf_mdio_pkt_data_we = 1'b0;
    wire         req_pready;
    wire  [15:0] req_prdata;
    wire  [4:0]  legal_phy_addr, legal_phy_addr_mask, broadcast_addr;
    wire         broadcast_mode, non_zero_detect, opendrain_mode, watchdog_enable, sync_select;
    wire  [8:0]  rf_pktctrl_gap, rf_pktctrl_phase;
    wire         rf_pktctrl_clk_en, rf_pktctrl_sw_rstn, rf_regfile_sw_rstn;
    wire         rf_self_test_mode, rf_capture_mode, rf_capture_start, rf_capture_again;
    wire         rf_96path_en, rf_mdio_read_pulse;
    wire  [1:0]  rf_pkt_data_length;
    wire  [15:0] rf_pkt_idle_length;
    wire  [6:0]  rf_mdio_data_sel;
    wire  [14:0] rf_mdio_memory_addr;
    wire  [2:0]  pulses;

    logic [15:0] got_q [$];
    logic [15:0] exp_q [$];
    string       what_q [$];
    int          queued = 0;
    int          checked = 0;
    int          errors = 0;
    logic [20:0] bad_addr [NUM_BAD] = '{21'd12, 21'd13, 21'd15, 21'h10, 21'h100002,
                                        21'h000402, 21'h1fffff};

    `include "tb_regfile_model.svh"

    assign pulses = {rf_capture_start, rf_capture_again, rf_mdio_read_pulse};

    top_regfile uut (
        .clk, .reset,
        .req_paddr, .req_pwrite, .req_psel, .req_penable, .req_pwdata,
        .req_pready, .req_prdata,
        .legal_phy_addr, .legal_phy_addr_mask, .broadcast_addr,
        .broadcast_mode, .non_zero_detect, .opendrain_mode, .watchdog_enable, .sync_select,
        .rf_pktctrl_gap, .rf_pktctrl_phase,
        .rf_pktctrl_clk_en, .rf_pktctrl_sw_rstn, .rf_regfile_sw_rstn,
        .rf_self_test_mode, .rf_capture_mode, .rf_capture_start, .rf_capture_again,
        .rf_96path_en, .rf_pkt_data_length, .rf_pkt_idle_length,
        .rf_mdio_read_pulse, .rf_mdio_data_sel, .rf_mdio_memory_addr,
        .rf_mdio_pkt_data, .rf_mdio_pkt_data_we
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Checking ----------------------------
    task automatic check_equal(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_value(input logic [15:0] got, input logic [15:0] exp,
                                input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        what_q.push_back(what);
        queued++;
    endtask

    initial begin : compare_proc
        forever begin
            wait (queued != checked);
            check_equal(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
            checked++;
        end
    end

    // Configuration outputs packed in word layout
    function automatic logic [15:0] output_word(input int idx);
        case (idx)
            0:  output_word = {1'b0, legal_phy_addr, legal_phy_addr_mask, broadcast_addr};
            1:  output_word = {11'd0, broadcast_mode, non_zero_detect, opendrain_mode,
                               watchdog_enable, sync_select};
            2:  output_word = {9'd0, rf_self_test_mode, rf_pkt_data_length, rf_capture_mode,
                               2'b00, rf_96path_en};
            3:  output_word = rf_pkt_idle_length;
            4:  output_word = {1'b0, rf_mdio_memory_addr};
            5:  output_word = {9'd0, rf_mdio_data_sel};
            8:  output_word = {7'd0, rf_pktctrl_gap};
            9:  output_word = {7'd0, rf_pktctrl_phase};
            10: output_word = {15'd0, rf_pktctrl_clk_en};
            11: output_word = {14'd0, rf_pktctrl_sw_rstn, rf_regfile_sw_rstn};
            default: output_word = 16'h0000;
        endcase
    endfunction

    // Bus access --------------------------
    task automatic finish_access();
        @(negedge clk);
        req_psel = 1'b0;
        req_penable = 1'b0;
        req_pwrite = 1'b0;
        #(CLK_PERIOD / 4);
        expect_value(req_pready, 1'b0, "pready while idle");
        expect_value(req_prdata, 16'h0000, "prdata while idle");
    endtask

    task automatic bus_write(input logic [20:0] addr, input logic [15:0] data);
        @(negedge clk);
        req_paddr = addr;
        req_pwrite = 1'b1;
        req_pwdata = data;
        req_psel = 1'b1;
        req_penable = 1'b0;
        @(negedge clk);
        req_penable = 1'b1;
        #(CLK_PERIOD / 4);
        expect_value(req_pready, 1'b1, "pready in write access");
        finish_access();
    endtask

    task automatic bus_read(input logic [20:0] addr, output logic [15:0] data);
        @(negedge clk);
        req_paddr = addr;
        req_pwrite = 1'b0;
        req_psel = 1'b1;
        req_penable = 1'b0;
        @(negedge clk);
        req_penable = 1'b1;
        #(CLK_PERIOD / 4);
        data = req_prdata;
        expect_value(req_pready, 1'b1, "pready in read access");
        finish_access();
    endtask

    // Whole map against the shadow copy
    task automatic check_map(input string what);
        logic [15:0] rd;
        for (int i = 0; i < 12; i++) begin
            bus_read(21'(i), rd);
            expect_value(rd, shadow[i], $sformatf("%s, word %0d readback", what, i));
            if (word_mask(i) != 16'h0000) begin
                expect_value(output_word(i), shadow[i],
                             $sformatf("%s, word %0d outputs", what, i));
            end
        end
    endtask

    task automatic pulse_check(input int idx, input logic [15:0] data,
                               input logic [2:0] exp_pulses);
        logic [15:0] rd;
        expect_value(pulses, 3'b000, "pulses low before write");
        bus_write(21'(idx), data);
        model_write(idx, data);
        expect_value(pulses, exp_pulses, $sformatf("pulses after write to word %0d", idx));
        @(posedge clk);
        #(CLK_PERIOD / 4);
        expect_value(pulses, 3'b000, "pulses cleared one cycle later");
        bus_read(21'(idx), rd);
        expect_value(rd, shadow[idx], $sformatf("word %0d readback after pulse", idx));
        if (word_mask(idx) != 16'h0000) begin
            expect_value(output_word(idx), shadow[idx], "word outputs after pulse");
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // Stimulus ----------------------------
    initial begin : stimulus
        logic [31:0] r;
        logic [15:0] rd;
        model_reset();
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Reset values
        expect_value(pulses, 3'b000, "pulses after reset");
        check_map("after reset");

        // Random writes to every read-write word
        for (int k = 0; k < ROUNDS; k++) begin
            for (int i = 0; i < 12; i++) begin
                if (word_mask(i) != 16'h0000) begin
                    draw_random(r);
                    bus_write(21'(i), r[15:0]);
                    model_write(i, r[15:0]);
                    expect_value(output_word(i), shadow[i],
                                 $sformatf("word %0d outputs after write", i));
                    bus_read(21'(i), rd);
                    expect_value(rd, shadow[i], $sformatf("word %0d readback", i));
                end
            end
        end

        // Self-clearing pulses
        draw_random(r);
        pulse_check(2, (r[15:0] & 16'hfff9) | 16'h0004, 3'b100);
        pulse_check(2, (r[31:16] & 16'hfff9) | 16'h0002, 3'b010);
        pulse_check(2, r[15:0] | 16'h0006, 3'b110);
        pulse_check(7, r[31:16] | 16'h0001, 3'b001);

        // Device-side status word
        for (int k = 0; k < PKT_ROUNDS; k++) begin
            draw_random(r);
            @(negedge clk);
            rf_mdio_pkt_data = r[8:0];
            rf_mdio_pkt_data_we = 1'b1;
            @(negedge clk);
            rf_mdio_pkt_data_we = 1'b0;
            shadow[6] = {7'd0, r[8:0]};
            bus_read(21'd6, rd);
            expect_value(rd, shadow[6], "status word after capture");
            bus_write(21'd6, r[31:16]);
            bus_read(21'd6, rd);
            expect_value(rd, shadow[6], "status word after bus write");
        end

        // Out-of-range addresses
        for (int k = 0; k < NUM_BAD; k++) begin
            draw_random(r);
            bus_write(bad_addr[k], r[15:0]);
            bus_read(bad_addr[k], rd);
            expect_value(rd, 16'h0000, $sformatf("read of address %h", bad_addr[k]));
        end
        check_map("after out-of-range writes");

        wait (checked == queued);
        $display("Checks: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/top_regfile.sv */
/*
 * Register file top: bus decoder, field storage, status capture and read path
 */
`default_nettype none

module top_regfile #(
    parameter regfile_pkg::phy_addr_t PHY_ADDR_INIT = regfile_pkg::PHY_ADDR_RST,
    parameter regfile_pkg::idle_len_t IDLE_LEN_INIT = regfile_pkg::IDLE_LEN_RST
) (
    input  wire                          clk,
    input  wire                          reset,
    // Bus
    input  wire regfile_pkg::paddr_t     req_paddr,
    input  wire                          req_pwrite,
    input  wire                          req_psel,
    input  wire                          req_penable,
    input  wire regfile_pkg::word_t      req_pwdata,
    output logic                         req_pready,
    output regfile_pkg::word_t           req_prdata,
    // Configuration outputs
    output regfile_pkg::phy_addr_t       legal_phy_addr,
    output regfile_pkg::phy_addr_t       legal_phy_addr_mask,
    output regfile_pkg::phy_addr_t       broadcast_addr,
    output logic                         broadcast_mode,
    output logic                         non_zero_detect,
    output logic                         opendrain_mode,
    output logic                         watchdog_enable,
    output logic                         sync_select,
    output regfile_pkg::pkt_data_t       rf_pktctrl_gap,
    output regfile_pkg::pkt_data_t       rf_pktctrl_phase,
    output logic                         rf_pktctrl_clk_en,
    output logic                         rf_pktctrl_sw_rstn,
    output logic                         rf_regfile_sw_rstn,
    output logic                         rf_self_test_mode,
    output logic                         rf_capture_mode,
    output logic                         rf_capture_start,
    output logic                         rf_capture_again,
    output logic                         rf_96path_en,
    output regfile_pkg::pkt_len_t        rf_pkt_data_length,
    output regfile_pkg::idle_len_t       rf_pkt_idle_length,
    output logic                         rf_mdio_read_pulse,
    output regfile_pkg::data_sel_t       rf_mdio_data_sel,
    output regfile_pkg::mdio_addr_t      rf_mdio_memory_addr,
    // Device side status
    input  wire regfile_pkg::pkt_data_t  rf_mdio_pkt_data,
    input  wire                          rf_mdio_pkt_data_we
);
    import regfile_pkg::*;

    logic [NUM_WORDS-1:0] wr_strobe;
    logic                 rd_en;
    word_idx_t            word_idx;
    word_t                wr_data;
    pkt_data_t            pkt_data;

    // ------------------------------
    apb_decode u_decode (
        .req_paddr   (req_paddr),
        .req_pwrite  (req_pwrite),
        .req_psel    (req_psel),
        .req_penable (req_penable),
        .req_pwdata  (req_pwdata),
        .req_pready  (req_pready),
        .wr_strobe   (wr_strobe),
        .rd_en       (rd_en),
        .word_idx    (word_idx),
        .wr_data     (wr_data)
    );

    // ------------------------------
    config_regs #(
        .PHY_ADDR_INIT (PHY_ADDR_INIT),
        .IDLE_LEN_INIT (IDLE_LEN_INIT)
    ) u_config (
        .clk, .reset, .wr_strobe, .wr_data,
        .legal_phy_addr, .legal_phy_addr_mask, .broadcast_addr,
        .broadcast_mode, .non_zero_detect, .opendrain_mode,
        .watchdog_enable, .sync_select,
        .rf_self_test_mode, .rf_pkt_data_length, .rf_capture_mode, .rf_96path_en,
        .rf_pkt_idle_length, .rf_mdio_memory_addr, .rf_mdio_data_sel,
        .rf_pktctrl_gap, .rf_pktctrl_phase,
        .rf_pktctrl_clk_en, .rf_pktctrl_sw_rstn, .rf_regfile_sw_rstn
    );

    pulse_regs u_pulse (
        .clk, .reset, .wr_strobe, .wr_data,
        .rf_capture_start, .rf_capture_again, .rf_mdio_read_pulse
    );

    status_capture u_status (
        .clk, .reset, .rf_mdio_pkt_data, .rf_mdio_pkt_data_we, .pkt_data
    );

    // ------------------------------
    read_mux u_read_mux (
        .rd_en, .word_idx,
        .legal_phy_addr, .legal_phy_addr_mask, .broadcast_addr,
        .broadcast_mode, .non_zero_detect, .opendrain_mode,
        .watchdog_enable, .sync_select,
        .rf_self_test_mode, .rf_pkt_data_length, .rf_capture_mode, .rf_96path_en,
        .rf_pkt_idle_length, .rf_mdio_memory_addr, .rf_mdio_data_sel,
        .pkt_data, .rf_pktctrl_gap, .rf_pktctrl_phase,
        .rf_pktctrl_clk_en, .rf_pktctrl_sw_rstn, .rf_regfile_sw_rstn,
        .req_prdata
    );

endmodule

`default_nettype wire

/* design/read_mux.sv */
/*
 * Read word assembly for the selected word index
 */
`default_nettype none

module read_mux (
    input  wire                          rd_en,
    input  wire regfile_pkg::word_idx_t  word_idx,
    input  wire regfile_pkg::phy_addr_t  legal_phy_addr,
    input  wire regfile_pkg::phy_addr_t  legal_phy_addr_mask,
    input  wire regfile_pkg::phy_addr_t  broadcast_addr,
    input  wire                          broadcast_mode,
    input  wire                          non_zero_detect,
    input  wire                          opendrain_mode,
    input  wire                          watchdog_enable,
    input  wire                          sync_select,
    input  wire                          rf_self_test_mode,
    input  wire regfile_pkg::pkt_len_t   rf_pkt_data_length,
    input  wire                          rf_capture_mode,
    input  wire                          rf_96path_en,
    input  wire regfile_pkg::idle_len_t  rf_pkt_idle_length,
    input  wire regfile_pkg::mdio_addr_t rf_mdio_memory_addr,
    input  wire regfile_pkg::data_sel_t  rf_mdio_data_sel,
    input  wire regfile_pkg::pkt_data_t  pkt_data,
    input  wire regfile_pkg::pkt_data_t  rf_pktctrl_gap,
    input  wire regfile_pkg::pkt_data_t  rf_pktctrl_phase,
    input  wire                          rf_pktctrl_clk_en,
    input  wire                          rf_pktctrl_sw_rstn,
    input  wire                          rf_regfile_sw_rstn,
    output regfile_pkg::word_t           req_prdata
);
    import regfile_pkg::*;

    word_t rd_word;

    always_comb begin
        case (word_idx)
            WORD_PHY_ADDR:   rd_word = {1'b0, legal_phy_addr, legal_phy_addr_mask, broadcast_addr};
            WORD_MODE:       rd_word = {11'd0, broadcast_mode, non_zero_detect, opendrain_mode,
                                        watchdog_enable, sync_select};
            // Pulse bits 2 and 1 read as 0
            WORD_CAPTURE:    rd_word = {9'd0, rf_self_test_mode, rf_pkt_data_length,
                                        rf_capture_mode, 2'b00, rf_96path_en};
            WORD_IDLE:       rd_word = rf_pkt_idle_length;
            WORD_MDIO_ADDR:  rd_word = {1'b0, rf_mdio_memory_addr};
            WORD_DATA_SEL:   rd_word = {9'd0, rf_mdio_data_sel};
            WORD_PKT_DATA:   rd_word = {7'd0, pkt_data};
            WORD_READ_PULSE: rd_word = '0;
            WORD_GAP:        rd_word = {7'd0, rf_pktctrl_gap};
            WORD_PHASE:      rd_word = {7'd0, rf_pktctrl_phase};
            WORD_CLK_EN:     rd_word = {15'd0, rf_pktctrl_clk_en};
            WORD_SW_RST:     rd_word = {14'd0, rf_pktctrl_sw_rstn, rf_regfile_sw_rstn};
            default:         rd_word = '0;
        endcase
    end

    assign req_prdata = rd_en ? rd_word : '0;

endmodule

`default_nettype wire

/* design/status_capture.sv */
/*
 * Packet data status word, loaded from the device side
 */
`default_nettype none

module status_capture (
    input  wire                         clk,
    input  wire                         reset,
    input  wire regfile_pkg::pkt_data_t rf_mdio_pkt_data,
    input  wire                         rf_mdio_pkt_data_we,
    output regfile_pkg::pkt_data_t      pkt_data
);
    import regfile_pkg::*;

    // Bus side has no write path here
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_data <= PKT_DATA_RST;
        end else if (rf_mdio_pkt_data_we) begin
            pkt_data <= rf_mdio_pkt_data;
        end
    end

endmodule

`default_nettype wire

/* design/pulse_regs.sv */
/*
 * Self-clearing command pulses for capture and MDIO read
 */
`default_nettype none

module pulse_regs (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [regfile_pkg::NUM_WORDS-1:0]  wr_strobe,
    input  wire regfile_pkg::word_t           wr_data,
    output logic                              rf_capture_start,
    output logic                              rf_capture_again,
    output logic                              rf_mdio_read_pulse
);
    import regfile_pkg::*;

    // High for one cycle after the committing edge, then back to 0
    always_ff @(posedge clk) begin
        if (reset) begin
            rf_capture_start   <= 1'b0;
            rf_capture_again   <= 1'b0;
            rf_mdio_read_pulse <= 1'b0;
        end else begin
            rf_capture_start   <= wr_strobe[WORD_CAPTURE] & wr_data[2];
            rf_capture_again   <= wr_strobe[WORD_CAPTURE] & wr_data[1];
            rf_mdio_read_pulse <= wr_strobe[WORD_READ_PULSE] & wr_data[0];
        end
    end

endmodule

`default_nettype wire

/* design/config_regs.sv */
/*
 * Read-write configuration fields with their reset values
 */
`default_nettype none

module config_regs #(
    parameter regfile_pkg::phy_addr_t PHY_ADDR_INIT = regfile_pkg::PHY_ADDR_RST,
    parameter regfile_pkg::idle_len_t IDLE_LEN_INIT = regfile_pkg::IDLE_LEN_RST
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [regfile_pkg::NUM_WORDS-1:0]  wr_strobe,
    input  wire regfile_pkg::word_t           wr_data,
    output regfile_pkg::phy_addr_t            legal_phy_addr,
    output regfile_pkg::phy_addr_t            legal_phy_addr_mask,
    output regfile_pkg::phy_addr_t            broadcast_addr,
    output logic                              broadcast_mode,
    output logic                              non_zero_detect,
    output logic                              opendrain_mode,
    output logic                              watchdog_enable,
    output logic                              sync_select,
    output logic                              rf_self_test_mode,
    output regfile_pkg::pkt_len_t             rf_pkt_data_length,
    output logic                              rf_capture_mode,
    output logic                              rf_96path_en,
    output regfile_pkg::idle_len_t            rf_pkt_idle_length,
    output regfile_pkg::mdio_addr_t           rf_mdio_memory_addr,
    output regfile_pkg::data_sel_t            rf_mdio_data_sel,
    output regfile_pkg::pkt_data_t            rf_pktctrl_gap,
    output regfile_pkg::pkt_data_t            rf_pktctrl_phase,
    output logic                              rf_pktctrl_clk_en,
    output logic                              rf_pktctrl_sw_rstn,
    output logic                              rf_regfile_sw_rstn
);
    import regfile_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            legal_phy_addr      <= PHY_ADDR_INIT;
            legal_phy_addr_mask <= PHY_ADDR_MASK_RST;
            broadcast_addr      <= BCAST_ADDR_RST;
            broadcast_mode      <= BCAST_MODE_RST;
            non_zero_detect     <= NON_ZERO_DETECT_RST;
            opendrain_mode      <= OPENDRAIN_MODE_RST;
            watchdog_enable     <= WATCHDOG_EN_RST;
            sync_select         <= SYNC_SELECT_RST;
            rf_self_test_mode   <= SELF_TEST_RST;
            rf_pkt_data_length  <= PKT_LEN_RST;
            rf_capture_mode     <= CAPTURE_MODE_RST;
            rf_96path_en        <= PATH96_EN_RST;
            rf_pkt_idle_length  <= IDLE_LEN_INIT;
            rf_mdio_memory_addr <= MDIO_ADDR_RST;
            rf_mdio_data_sel    <= DATA_SEL_RST;
            rf_pktctrl_gap      <= GAP_RST;
            rf_pktctrl_phase    <= PHASE_RST;
            rf_pktctrl_clk_en   <= CLK_EN_RST;
            rf_pktctrl_sw_rstn  <= PKTCTRL_SW_RSTN_RST;
            rf_regfile_sw_rstn  <= REGFILE_SW_RSTN_RST;
        end else begin
            // PHY addressing
            if (wr_strobe[WORD_PHY_ADDR]) begin
                legal_phy_addr      <= wr_data[14:10];
                legal_phy_addr_mask <= wr_data[9:5];
                broadcast_addr      <= wr_data[4:0];
            end
            if (wr_strobe[WORD_MODE]) begin
                broadcast_mode  <= wr_data[4];
                non_zero_detect <= wr_data[3];
                opendrain_mode  <= wr_data[2];
                watchdog_enable <= wr_data[1];
                sync_select     <= wr_data[0];
            end
            // Bits 2 and 1 of this word belong to the pulse block
            if (wr_strobe[WORD_CAPTURE]) begin
                rf_self_test_mode  <= wr_data[6];
                rf_pkt_data_length <= wr_data[5:4];
                rf_capture_mode    <= wr_data[3];
                rf_96path_en       <= wr_data[0];
            end
            if (wr_strobe[WORD_IDLE]) begin
                rf_pkt_idle_length <= wr_data;
            end
            if (wr_strobe[WORD_MDIO_ADDR]) begin
                rf_mdio_memory_addr <= wr_data[14:0];
            end
            if (wr_strobe[WORD_DATA_SEL]) begin
                rf_mdio_data_sel <= wr_data[6:0];
            end
            // Packet controller
            if (wr_strobe[WORD_GAP]) begin
                rf_pktctrl_gap <= wr_data[8:0];
            end
            if (wr_strobe[WORD_PHASE]) begin
                rf_pktctrl_phase <= wr_data[8:0];
            end
            if (wr_strobe[WORD_CLK_EN]) begin
                rf_pktctrl_clk_en <= wr_data[0];
            end
            if (wr_strobe[WORD_SW_RST]) begin
                rf_pktctrl_sw_rstn <= wr_data[1];
                rf_regfile_sw_rstn <= wr_data[0];
            end
        end
    end

endmodule

`default_nettype wire

/* design/apb_decode.sv */
/*
 * Bus decoder: access phase, address range check, write strobes and ready
 */
`default_nettype none

module apb_decode (
    input  wire regfile_pkg::paddr_t          req_paddr,
    input  wire                               req_pwrite,
    input  wire                               req_psel,
    input  wire                               req_penable,
    input  wire regfile_pkg::word_t           req_pwdata,
    output logic                              req_pready,
    output logic [regfile_pkg::NUM_WORDS-1:0] wr_strobe,
    output logic                              rd_en,
    output regfile_pkg::word_idx_t            word_idx,
    output regfile_pkg::word_t                wr_data
);
    import regfile_pkg::*;

    logic access;
    logic in_range;
    logic wr_en;

    // Zero wait states, so ready is just the access phase
    assign access     = req_psel & req_penable;
    assign req_pready = access;

    // Any high address bit lands above the map
    assign in_range = (req_paddr < paddr_t'(NUM_WORDS));
    assign word_idx = req_paddr[$bits(word_idx_t)-1:0];

    assign wr_en = access & req_pwrite & in_range;
    assign rd_en = access & ~req_pwrite & in_range;

    always_comb begin
        for (int i = 0; i < NUM_WORDS; i++) begin
            wr_strobe[i] = wr_en && (word_idx == word_idx_t'(i));
        end
    end

    assign wr_data = req_pwdata;

endmodule

`default_nettype wire

/* design/regfile_pkg.sv */
/*
 * Field types, word indices and reset values of the PHY packet controller register map
 */
`default_nettype none

package regfile_pkg;

    typedef logic [20:0] paddr_t;
    typedef logic [15:0] word_t;
    typedef logic [3:0]  word_idx_t;
    typedef logic [4:0]  phy_addr_t;
    typedef logic [1:0]  pkt_len_t;
    typedef logic [15:0] idle_len_t;
    typedef logic [14:0] mdio_addr_t;
    typedef logic [6:0]  data_sel_t;
    typedef logic [8:0]  pkt_data_t;

    // Word map ------------------------
    localparam word_idx_t WORD_PHY_ADDR   = 4'h0;
    localparam word_idx_t WORD_MODE       = 4'h1;
    localparam word_idx_t WORD_CAPTURE    = 4'h2;
    localparam word_idx_t WORD_IDLE       = 4'h3;
    localparam word_idx_t WORD_MDIO_ADDR  = 4'h4;
    localparam word_idx_t WORD_DATA_SEL   = 4'h5;
    localparam word_idx_t WORD_PKT_DATA   = 4'h6;
    localparam word_idx_t WORD_READ_PULSE = 4'h7;
    localparam word_idx_t WORD_GAP        = 4'h8;
    localparam word_idx_t WORD_PHASE      = 4'h9;
    localparam word_idx_t WORD_CLK_EN     = 4'ha;
    localparam word_idx_t WORD_SW_RST     = 4'hb;
    localparam int        NUM_WORDS       = 12;

    // Reset values --------------------
    localparam phy_addr_t  PHY_ADDR_RST        = 5'd31;
    localparam phy_addr_t  PHY_ADDR_MASK_RST   = 5'd31;
    localparam phy_addr_t  BCAST_ADDR_RST      = 5'd31;
    localparam logic       BCAST_MODE_RST      = 1'b1;
    localparam logic       NON_ZERO_DETECT_RST = 1'b0;
    localparam logic       OPENDRAIN_MODE_RST  = 1'b1;
    localparam logic       WATCHDOG_EN_RST     = 1'b0;
    localparam logic       SYNC_SELECT_RST     = 1'b0;
    localparam logic       SELF_TEST_RST       = 1'b0;
    localparam pkt_len_t   PKT_LEN_RST         = 2'd0;
    localparam logic       CAPTURE_MODE_RST    = 1'b0;
    localparam logic       PATH96_EN_RST       = 1'b1;
    localparam idle_len_t  IDLE_LEN_RST        = 16'd32767;
    localparam mdio_addr_t MDIO_ADDR_RST       = 15'd0;
    localparam data_sel_t  DATA_SEL_RST        = 7'd0;
    localparam pkt_data_t  PKT_DATA_RST        = 9'd0;
    localparam pkt_data_t  GAP_RST             = 9'd0;
    localparam pkt_data_t  PHASE_RST           = 9'd0;
    localparam logic       CLK_EN_RST          = 1'b1;
    localparam logic       PKTCTRL_SW_RSTN_RST = 1'b1;
    localparam logic       REGFILE_SW_RSTN_RST = 1'b1;

endpackage

`default_nettype wire
